// File: design/lat_stats_pkg.sv
`default_nettype none

package lat_stats_pkg;

    localparam int TIMESTAMP_W = 32;
    localparam int LOG_ENTRY_W = 2 * TIMESTAMP_W;
    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_RESP_W = 2;

    // cycle timestamp, also used for latencies.
    typedef logic [TIMESTAMP_W-1:0] timestamp_t;

    // upper word is the start timestamp, lower word the latency.
    typedef logic [LOG_ENTRY_W-1:0] log_entry_t;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_RESP_W-1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // register map.
    localparam axil_addr_t STATUS_ADDR = 12'h000;
    localparam axil_addr_t ENTRY_BASE  = 12'h100;

    // each entry takes two words: latency first, then start.
    localparam int ENTRY_BYTES = 8;

endpackage

`default_nettype wire

// File: design/lat_log_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface log_rd_if #(
    parameter int LOG_DEPTH_LOG2 = 4
);
    import lat_stats_pkg::*;

    logic                      req;
    logic [LOG_DEPTH_LOG2-1:0] addr;
    logic                      gnt;
    logic                      rvalid;
    log_entry_t                rdata;

    modport reader (output req, addr, input gnt, rvalid, rdata);
    modport arbiter (input req, addr, output gnt, rvalid, rdata);
endinterface

interface log_mem_if #(
    parameter int LOG_DEPTH_LOG2 = 4
);
    import lat_stats_pkg::*;

    logic                      wr_en;
    log_entry_t                wdata;
    logic                      rd_en;
    logic [LOG_DEPTH_LOG2-1:0] rd_addr;
    log_entry_t                rd_data;

    modport master (output wr_en, wdata, rd_en, rd_addr, input rd_data);
    modport memory (input wr_en, wdata, rd_en, rd_addr, output rd_data);
endinterface

`default_nettype wire

// File: design/lat_recorder.sv
`timescale 1ns/1ps
`default_nettype none

module lat_recorder (
     input  logic                      clk
    ,input  logic                      rst_n

    ,input  logic                      log_pulse
    ,input  lat_stats_pkg::timestamp_t start_ts

    ,output logic                      wr_val
    ,output lat_stats_pkg::log_entry_t wr_data
);
    import lat_stats_pkg::*;

    timestamp_t ts_cnt;
    timestamp_t latency;

    // wraps modulo 2^32, same as the counter.
    assign latency = ts_cnt - start_ts;

    // free-running timestamp, 0 at the first edge after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts_cnt <= '0;
            wr_val <= 1'b0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
            wr_val <= log_pulse;
        end
    end

    always_ff @(posedge clk) begin
        if (log_pulse) begin
            wr_data <= {start_ts, latency};
        end
    end

endmodule

`default_nettype wire

// File: design/log_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module log_arbiter #(
    parameter int LOG_DEPTH_LOG2 = 4
)(
     input  logic                      clk
    ,input  logic                      rst_n

    ,input  logic                      wr_val
    ,input  lat_stats_pkg::log_entry_t wr_data

    ,log_rd_if.arbiter                 rd
    ,log_mem_if.master                 mem
);
    logic                      rd_grant;
    logic                      rd_inflight;
    logic [LOG_DEPTH_LOG2-1:0] rd_idx;

    // writes always win, a read only goes through on a free cycle.
    assign rd_grant = rd.req && !wr_val;
    assign rd_idx   = rd.addr;

    assign mem.wr_en   = wr_val;
    assign mem.wdata   = wr_data;
    assign mem.rd_en   = rd_grant;
    assign mem.rd_addr = rd_idx;

    assign rd.gnt = rd_grant;

    // the memory answers one cycle after the grant.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_inflight <= 1'b0;
        end else begin
            rd_inflight <= rd_grant;
        end
    end

    assign rd.rvalid = rd_inflight;
    assign rd.rdata  = mem.rd_data;

endmodule

`default_nettype wire

// File: design/log_mem.sv
`timescale 1ns/1ps
`default_nettype none

module log_mem #(
    parameter int LOG_DEPTH_LOG2 = 4
)(
     input  logic                      clk
    ,input  logic                      rst_n

    ,log_mem_if.memory                 mem

    ,output logic [LOG_DEPTH_LOG2-1:0] wr_ptr
    ,output logic                      wrapped
);
    import lat_stats_pkg::*;

    localparam int DEPTH = 2 ** LOG_DEPTH_LOG2;

    log_entry_t store [DEPTH];

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            store[wr_ptr] <= mem.wdata;
        end
        if (mem.rd_en) begin
            mem.rd_data <= store[mem.rd_addr];
        end
    end

    // pointer advances on every write, wrapped is sticky.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            wrapped <= 1'b0;
        end else if (mem.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (&wr_ptr) begin
                wrapped <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/axil_log_reader.sv
`timescale 1ns/1ps
`default_nettype none

module axil_log_reader #(
    parameter int LOG_DEPTH_LOG2 = 4
)(
     input  logic                      clk
    ,input  logic                      rst_n

    ,input  logic                      awvalid
    ,output logic                      awready
    ,input  lat_stats_pkg::axil_addr_t awaddr
    ,input  logic                      wvalid
    ,output logic                      wready
    ,input  lat_stats_pkg::axil_data_t wdata
    ,input  logic [3:0]                wstrb
    ,output logic                      bvalid
    ,input  logic                      bready
    ,output lat_stats_pkg::axil_resp_t bresp

    ,input  logic                      arvalid
    ,output logic                      arready
    ,input  lat_stats_pkg::axil_addr_t araddr
    ,output logic                      rvalid
    ,input  logic                      rready
    ,output lat_stats_pkg::axil_data_t rdata
    ,output lat_stats_pkg::axil_resp_t rresp

    ,log_rd_if.reader                  rd

    ,input  logic [LOG_DEPTH_LOG2-1:0] wr_ptr
    ,input  logic                      wrapped
);
    import lat_stats_pkg::*;

    localparam int WINDOW_BYTES = ENTRY_BYTES << LOG_DEPTH_LOG2;

    typedef enum logic [1:0] {IDLE, FETCH, RESP} rd_state_e;
    typedef enum logic {COLLECT, BRESP} wr_state_e;

    rd_state_e  rd_state;
    wr_state_e  wr_state;
    axil_addr_t entry_off;
    logic       ar_is_status;
    logic       ar_is_entry;
    logic       half_sel;
    axil_data_t status_word;
    logic       aw_got;
    logic       w_got;
    logic       aw_now;
    logic       w_now;

    assign entry_off    = araddr - ENTRY_BASE;
    assign ar_is_status = (araddr == STATUS_ADDR);
    assign ar_is_entry  = (araddr >= ENTRY_BASE) && (entry_off < WINDOW_BYTES)
                          && (araddr[1:0] == 2'b00);
    assign status_word  = {wrapped, {(AXIL_DATA_W-1-LOG_DEPTH_LOG2){1'b0}}, wr_ptr};

    // one read in flight at a time.
    assign arready = (rd_state == IDLE);
    assign rvalid  = (rd_state == RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= IDLE;
            rd.req   <= 1'b0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (arvalid) begin
                        if (ar_is_entry) begin
                            rd_state <= FETCH;
                            rd.req   <= 1'b1;
                        end else begin
                            rd_state <= RESP;
                        end
                    end
                end
                FETCH: begin
                    if (rd.gnt) begin
                        rd.req <= 1'b0;
                    end
                    if (rd.rvalid) begin
                        rd_state <= RESP;
                    end
                end
                RESP: begin
                    if (rready) begin
                        rd_state <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == IDLE && arvalid) begin
            rd.addr  <= entry_off[LOG_DEPTH_LOG2+2:3];
            half_sel <= entry_off[2];
            if (ar_is_status) begin
                rdata <= status_word;
                rresp <= RESP_OKAY;
            end else if (!ar_is_entry) begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end else if (rd_state == FETCH && rd.rvalid) begin
            // offset 4 selects the start word.
            rdata <= half_sel ? rd.rdata[2*AXIL_DATA_W-1:AXIL_DATA_W]
                              : rd.rdata[AXIL_DATA_W-1:0];
            rresp <= RESP_OKAY;
        end
    end

    // the log is read-only, so awaddr, wdata and wstrb carry nothing we keep.
    assign awready = (wr_state == COLLECT) && !aw_got;
    assign wready  = (wr_state == COLLECT) && !w_got;
    assign bvalid  = (wr_state == BRESP);
    assign bresp   = RESP_SLVERR;

    assign aw_now = aw_got || (awvalid && awready);
    assign w_now  = w_got || (wvalid && wready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= COLLECT;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            case (wr_state)
                COLLECT: begin
                    if (aw_now && w_now) begin
                        wr_state <= BRESP;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                    end else begin
                        aw_got <= aw_now;
                        w_got  <= w_now;
                    end
                end
                BRESP: begin
                    if (bready) begin
                        wr_state <= COLLECT;
                    end
                end
                default: wr_state <= COLLECT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/eth_latency_stats.sv
`timescale 1ns/1ps
`default_nettype none

module eth_latency_stats #(
    parameter int LOG_DEPTH_LOG2 = 4
)(
     input  logic                      clk
    ,input  logic                      rst_n

    ,input  logic                      log_pulse
    ,input  lat_stats_pkg::timestamp_t start_ts

    ,input  logic                      awvalid
    ,output logic                      awready
    ,input  lat_stats_pkg::axil_addr_t awaddr
    ,input  logic                      wvalid
    ,output logic                      wready
    ,input  lat_stats_pkg::axil_data_t wdata
    ,input  logic [3:0]                wstrb
    ,output logic                      bvalid
    ,input  logic                      bready
    ,output lat_stats_pkg::axil_resp_t bresp

    ,input  logic                      arvalid
    ,output logic                      arready
    ,input  lat_stats_pkg::axil_addr_t araddr
    ,output logic                      rvalid
    ,input  logic                      rready
    ,output lat_stats_pkg::axil_data_t rdata
    ,output lat_stats_pkg::axil_resp_t rresp
);
    import lat_stats_pkg::*;

    logic                      wr_val;
    log_entry_t                wr_data;
    logic [LOG_DEPTH_LOG2-1:0] wr_ptr;
    logic                      wrapped;

    log_rd_if  #(.LOG_DEPTH_LOG2(LOG_DEPTH_LOG2)) rd_bus ();
    log_mem_if #(.LOG_DEPTH_LOG2(LOG_DEPTH_LOG2)) mem_bus ();

    lat_recorder recorder (
         .clk       (clk        )
        ,.rst_n     (rst_n      )
        ,.log_pulse (log_pulse  )
        ,.start_ts  (start_ts   )
        ,.wr_val    (wr_val     )
        ,.wr_data   (wr_data    )
    );

    log_arbiter #(
        .LOG_DEPTH_LOG2 (LOG_DEPTH_LOG2 )
    ) arbiter (
         .clk       (clk        )
        ,.rst_n     (rst_n      )
        ,.wr_val    (wr_val     )
        ,.wr_data   (wr_data    )
        ,.rd        (rd_bus     )
        ,.mem       (mem_bus    )
    );

    log_mem #(
        .LOG_DEPTH_LOG2 (LOG_DEPTH_LOG2 )
    ) stats_log (
         .clk       (clk        )
        ,.rst_n     (rst_n      )
        ,.mem       (mem_bus    )
        ,.wr_ptr    (wr_ptr     )
        ,.wrapped   (wrapped    )
    );

    axil_log_reader #(
        .LOG_DEPTH_LOG2 (LOG_DEPTH_LOG2 )
    ) reader (
         .clk       (clk        )
        ,.rst_n     (rst_n      )
        ,.awvalid   (awvalid    )
        ,.awready   (awready    )
        ,.awaddr    (awaddr     )
        ,.wvalid    (wvalid     )
        ,.wready    (wready     )
        ,.wdata     (wdata      )
        ,.wstrb     (wstrb      )
        ,.bvalid    (bvalid     )
        ,.bready    (bready     )
        ,.bresp     (bresp      )
        ,.arvalid   (arvalid    )
        ,.arready   (arready    )
        ,.araddr    (araddr     )
        ,.rvalid    (rvalid     )
        ,.rready    (rready     )
        ,.rdata     (rdata      )
        ,.rresp     (rresp      )
        ,.rd        (rd_bus     )
        ,.wr_ptr    (wr_ptr     )
        ,.wrapped   (wrapped    )
    );

endmodule

`default_nettype wire

// File: sim/eth_latency_stats_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module eth_latency_stats_asserts (
     input  logic                      clk
    ,input  logic                      rst_n
    ,input  logic                      arvalid
    ,input  logic                      arready
    ,input  logic                      rvalid
    ,input  logic                      rready
    ,input  lat_stats_pkg::axil_data_t rdata
    ,input  lat_stats_pkg::axil_resp_t rresp
    ,input  logic                      bvalid
    ,input  logic                      bready
    ,input  lat_stats_pkg::axil_resp_t bresp
);
    import lat_stats_pkg::*;

    int   fail_count = 0;
    logic rd_open;

    // set from the AR handshake until the R handshake.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_open <= 1'b0;
        end else if (arvalid && arready) begin
            rd_open <= 1'b1;
        end else if (rvalid && rready) begin
            rd_open <= 1'b0;
        end
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("R channel changed while stalled");
            fail_count++;
        end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("B channel changed while stalled");
            fail_count++;
        end

    ar_block: assert property (@(posedge clk) disable iff (!rst_n) rd_open |-> !arready)
        else begin
            $error("arready high with a read outstanding");
            fail_count++;
        end

    b_slverr: assert property (@(posedge clk) disable iff (!rst_n) bresp == RESP_SLVERR)
        else begin
            $error("bresp is not SLVERR");
            fail_count++;
        end

endmodule

bind axil_log_reader eth_latency_stats_asserts asserts0 (
     .clk     (clk    )
    ,.rst_n   (rst_n  )
    ,.arvalid (arvalid)
    ,.arready (arready)
    ,.rvalid  (rvalid )
    ,.rready  (rready )
    ,.rdata   (rdata  )
    ,.rresp   (rresp  )
    ,.bvalid  (bvalid )
    ,.bready  (bready )
    ,.bresp   (bresp  )
);

`default_nettype wire

// File: sim/eth_latency_stats_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eth_latency_stats_checker #(
    parameter int LOG_DEPTH_LOG2 = 4
)(
     input  logic                      clk
    ,input  logic                      rst_n
    ,input  logic                      log_pulse
    ,input  lat_stats_pkg::timestamp_t start_ts
    ,input  logic                      arvalid
    ,input  logic                      arready
    ,input  lat_stats_pkg::axil_addr_t araddr
    ,input  logic                      rvalid
    ,input  logic                      rready
    ,input  lat_stats_pkg::axil_data_t rdata
    ,input  lat_stats_pkg::axil_resp_t rresp
    ,input  logic                      bvalid
    ,input  logic                      bready
    ,input  lat_stats_pkg::axil_resp_t bresp
    ,input  lat_stats_pkg::axil_resp_t exp_resp
    ,output int                        errors
    ,output int                        r_beats
    ,output int                        b_beats
);
    import lat_stats_pkg::*;

    localparam int DEPTH = 2 ** LOG_DEPTH_LOG2;

    timestamp_t  ts        = '0;
    log_entry_t  model_log [DEPTH];
    int unsigned wr_ptr_m  = 0;
    logic        wrapped_m = 1'b0;
    logic        pend      = 1'b0;
    log_entry_t  pend_entry;
    logic        rd_open   = 1'b0;
    axil_addr_t  rd_addr_m;
    axil_data_t  exp_rdata;
    axil_resp_t  exp_rresp;
    log_entry_t  slot;
    int          byte_off;
    int          err_cnt   = 0;
    int          r_cnt     = 0;
    int          b_cnt     = 0;

    assign errors  = err_cnt;
    assign r_beats = r_cnt;
    assign b_beats = b_cnt;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts        = '0;
            wr_ptr_m  = 0;
            wrapped_m = 1'b0;
            pend      = 1'b0;
            rd_open   = 1'b0;
        end else begin
            if (rvalid && rready) begin
                r_cnt++;
                if (!rd_open) begin
                    $display("R beat at %0t with no read outstanding", $time);
                    err_cnt++;
                end else if (rdata !== exp_rdata || rresp !== exp_rresp) begin
                    $display("MISMATCH at %0t: read 0x%03h gave %08h/%0d, expected %08h/%0d",
                             $time, rd_addr_m, rdata, rresp, exp_rdata, exp_rresp);
                    err_cnt++;
                end
                if (rd_open && rresp !== exp_resp) begin
                    $display("MISMATCH at %0t: read 0x%03h rresp %0d, stim expects %0d",
                             $time, rd_addr_m, rresp, exp_resp);
                    err_cnt++;
                end
                rd_open = 1'b0;
            end
            if (bvalid && bready) begin
                b_cnt++;
                if (bresp !== RESP_SLVERR || bresp !== exp_resp) begin
                    $display("MISMATCH at %0t: bresp %0d, expected %0d", $time, bresp, exp_resp);
                    err_cnt++;
                end
            end
            // status sees the pointer as it was before this edge.
            if (arvalid && arready) begin
                rd_addr_m = araddr;
                rd_open   = 1'b1;
                exp_rresp = RESP_OKAY;
                exp_rdata = {wrapped_m, 31'(wr_ptr_m)};
            end
            if (pend) begin
                model_log[wr_ptr_m] = pend_entry;
                if (wr_ptr_m == DEPTH - 1) wrapped_m = 1'b1;
                wr_ptr_m = (wr_ptr_m + 1) % DEPTH;
            end
            if (arvalid && arready && araddr != STATUS_ADDR) begin
                byte_off = int'(araddr) - int'(ENTRY_BASE);
                if (araddr[1:0] == 2'b00 && byte_off >= 0 && byte_off < 8 * DEPTH) begin
                    slot      = model_log[byte_off / 8];
                    exp_rdata = araddr[2] ? slot[63:32] : slot[31:0];
                end else begin
                    exp_rdata = '0;
                    exp_rresp = RESP_SLVERR;
                end
            end
            // entry lands in the log one cycle after the pulse.
            pend       = log_pulse;
            pend_entry = {start_ts, ts - start_ts};
            ts         = ts + 1;
        end
    end

endmodule

`default_nettype wire

// File: sim/eth_latency_stats_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_latency_stats_tb;
    import lat_stats_pkg::*;

    localparam int    LOG_DEPTH_LOG2 = 4;
    localparam int    CLK_PERIOD     = 100;
    localparam string STIM_FILE      = "sim/eth_latency_stats_stim.txt";

    logic       clk;
    logic       rst_n;
    logic       log_pulse;
    timestamp_t start_ts;
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bvalid;
    logic       bready;
    axil_resp_t bresp;
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    axil_data_t rdata;
    axil_resp_t rresp;

    axil_resp_t  exp_resp;
    int          mismatches;
    int          r_beats;
    int          b_beats;
    int          reads_issued  = 0;
    int          writes_issued = 0;
    int          file_errors   = 0;
    int          budget_cycles = 0;
    logic [31:0] lfsr_state;

    // one entry per stim line, arguments by column.
    logic [7:0]  cmd_q  [$];
    logic [31:0] arg0_q [$];
    logic [31:0] arg1_q [$];
    logic [31:0] arg2_q [$];
    logic [31:0] arg3_q [$];

    eth_latency_stats #(
        .LOG_DEPTH_LOG2 (LOG_DEPTH_LOG2)
    ) dut0 (
         .clk       (clk      )
        ,.rst_n     (rst_n    )
        ,.log_pulse (log_pulse)
        ,.start_ts  (start_ts )
        ,.awvalid   (awvalid  )
        ,.awready   (awready  )
        ,.awaddr    (awaddr   )
        ,.wvalid    (wvalid   )
        ,.wready    (wready   )
        ,.wdata     (wdata    )
        ,.wstrb     (wstrb    )
        ,.bvalid    (bvalid   )
        ,.bready    (bready   )
        ,.bresp     (bresp    )
        ,.arvalid   (arvalid  )
        ,.arready   (arready  )
        ,.araddr    (araddr   )
        ,.rvalid    (rvalid   )
        ,.rready    (rready   )
        ,.rdata     (rdata    )
        ,.rresp     (rresp    )
    );

    eth_latency_stats_checker #(
        .LOG_DEPTH_LOG2 (LOG_DEPTH_LOG2)
    ) check0 (
         .clk        (clk       )
        ,.rst_n      (rst_n     )
        ,.log_pulse  (log_pulse )
        ,.start_ts   (start_ts  )
        ,.arvalid    (arvalid   )
        ,.arready    (arready   )
        ,.araddr     (araddr    )
        ,.rvalid     (rvalid    )
        ,.rready     (rready    )
        ,.rdata      (rdata     )
        ,.rresp      (rresp     )
        ,.bvalid     (bvalid    )
        ,.bready     (bready    )
        ,.bresp      (bresp     )
        ,.exp_resp   (exp_resp  )
        ,.errors     (mismatches)
        ,.r_beats    (r_beats   )
        ,.b_beats    (b_beats   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_log(input timestamp_t ts);
        log_pulse = 1'b1;
        start_ts  = ts;
        next_cycle();
        log_pulse = 1'b0;
    endtask

    task automatic pulse_burst(input timestamp_t first, input int count);
        for (int i = 0; i < count; i++) begin
            pulse_log(first + timestamp_t'(i));
        end
    endtask

    task automatic axi_read(input axil_addr_t addr, input axil_resp_t resp);
        int stall;
        exp_resp = resp;
        arvalid  = 1'b1;
        araddr   = addr;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        while (!rvalid) next_cycle();
        // hold rready low for a random number of cycles.
        take_bits(2, stall);
        repeat (stall) next_cycle();
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
        reads_issued++;
    endtask

    task automatic send_aw(input axil_addr_t addr);
        awvalid = 1'b1;
        awaddr  = addr;
        while (!awready) next_cycle();
        next_cycle();
        awvalid = 1'b0;
    endtask

    task automatic send_w(input axil_data_t data);
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = 4'hf;
        while (!wready) next_cycle();
        next_cycle();
        wvalid = 1'b0;
    endtask

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             input logic [31:0] order, input axil_resp_t resp);
        int stall;
        exp_resp = resp;
        case (order)
            0: begin
                send_aw(addr);
                send_w(data);
            end
            1: begin
                send_w(data);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data);
                join
            end
        endcase
        while (!bvalid) next_cycle();
        take_bits(2, stall);
        repeat (stall) next_cycle();
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
        writes_issued++;
    endtask

    task automatic run_command(input logic [7:0] c, input logic [31:0] a0,
                               input logic [31:0] a1, input logic [31:0] a2,
                               input logic [31:0] a3);
        case (c)
            "L": pulse_log(a0);
            "B": pulse_burst(a0, a1);
            "R": axi_read(a0[11:0], a1[1:0]);
            "W": axi_write(a0[11:0], a1, a2, a3[1:0]);
            "I": repeat (a0) next_cycle();
            "P": begin
                // log pulses keep the arbiter busy while the read waits.
                fork
                    pulse_burst(a2, a3);
                    axi_read(a0[11:0], a1[1:0]);
                join
            end
            default: begin
                $display("unknown stimulus command '%c'", c);
                file_errors++;
            end
        endcase
    endtask

    task automatic load_stim(output bit ok);
        int          fd;
        int          idle_sum;
        string       line;
        logic [7:0]  c;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        idle_sum = 0;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        if (!ok) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                a0 = '0;
                a1 = '0;
                a2 = '0;
                a3 = '0;
                void'($sscanf(line, "%c %h %h %h %h", c, a0, a1, a2, a3));
                cmd_q.push_back(c);
                arg0_q.push_back(a0);
                arg1_q.push_back(a1);
                arg2_q.push_back(a2);
                arg3_q.push_back(a3);
                if (c == "I") idle_sum += int'(a0);
                if (c == "B") idle_sum += int'(a1);
                if (c == "P") idle_sum += int'(a3);
            end
            $fclose(fd);
            budget_cycles = 2 * (idle_sum + 40 * cmd_q.size());
        end
    endtask

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * CLK_PERIOD);
        $display("watchdog: run timed out after %0d cycles", budget_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit stim_ok;
        int lost;
        int total;
        rst_n      = 1'b0;
        log_pulse  = 1'b0;
        start_ts   = '0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        exp_resp   = RESP_OKAY;
        lfsr_state = 32'hcef1_8ba2;

        load_stim(stim_ok);
        if (stim_ok) begin
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            for (int i = 0; i < cmd_q.size(); i++) begin
                run_command(cmd_q[i], arg0_q[i], arg1_q[i], arg2_q[i], arg3_q[i]);
            end
            repeat (4) next_cycle();
        end else begin
            file_errors++;
        end

        lost  = (reads_issued != r_beats) + (writes_issued != b_beats);
        total = mismatches + dut0.reader.asserts0.fail_count + lost + file_errors;
        $display("errors: %0d mismatches, %0d assertion failures, %0d lost responses, %0d stim",
                 mismatches, dut0.reader.asserts0.fail_count, lost, file_errors);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/eth_latency_stats_stim.txt
# L start | B start count | R addr resp | P addr resp start count (read with pulses)
# W addr data order resp (order 0 aw first, 1 w first, 2 both) | I cycles; all hex
R 000 0
L 00000010
I 3
L 00000000
L fffffff0
I 5
R 100 0
R 104 0
R 108 0
R 10c 0
R 110 0
R 114 0
R 000 0
P 104 0 00000100 6
R 11c 0
R 140 0
R 144 0
B 00000200 b
I 2
R 000 0
R 100 0
R 104 0
R 11c 0
R 120 0
R 102 2
R 180 2
R 004 2
W 000 12345678 0 2
W 104 89abcdef 1 2
W 108 00000000 2 2
R 000 0

// File: flist.f
design/lat_stats_pkg.sv
design/lat_log_ifs.sv
design/lat_recorder.sv
design/log_arbiter.sv
design/log_mem.sv
design/axil_log_reader.sv
design/eth_latency_stats.sv
sim/eth_latency_stats_asserts.sv
sim/eth_latency_stats_checker.sv
sim/eth_latency_stats_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module eth_latency_stats_tb \
    -f flist.f -o eth_latency_stats_sim \
    && ./obj_dir/eth_latency_stats_sim | tee /dev/stderr | grep "TEST OK" > /dev/null \
    || { echo "simulation failed"; exit 1; }
